// ==== compile.f ====
verilog/wb_pkg.sv
verilog/reg_file.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/div_unit.sv
verilog/writeback.sv
verilog/exec_backend_top.sv
sim/tb_exec_backend.sv

// ==== Bender.yml ====
package:
  name: exec_backend

sources:
  # Shared package, compiled first
  - files:
      - verilog/wb_pkg.sv
  # RTL
  - files:
      - verilog/reg_file.sv
      - verilog/alu_unit.sv
      - verilog/mul_unit.sv
      - verilog/div_unit.sv
      - verilog/writeback.sv
      - verilog/exec_backend_top.sv
  # Testbench
  - target: simulation
    files:
      - sim/tb_exec_backend.sv

// ==== sim/tb_exec_backend.sv ====
/*
 * Execution backend testbench
 * Directed tests for ALU, multiplier, divider and writeback priority,
 * checked against a reference register array and operation model
 */

`timescale 1ns/1ps

module tb_exec_backend;
    import wb_pkg::*;

    localparam int RESET_CYCLES   = 16;
    localparam int NUM_TESTS      = 5;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 200 + RESET_CYCLES;

    logic                    clk;
    logic                    rst_n;
    issue_t                  issue;
    logic                    issue_valid;
    logic [NUM_WB_UNITS-1:0] unit_ready;
    wb_packet_t              wb_packet;

    // Reference state
    logic [XLEN-1:0] ref_regs [2**REG_ADDR_W];
    logic [XLEN-1:0] rng_state = 32'h6a39;
    id_t             next_id = '0;
    int              errors = 0;
    int              cycle_cnt = 0;
    // Observed writeback stream and the cycle of each packet
    wb_packet_t      pkt_q [$];
    int              stamp_q [$];

    exec_backend_top uut (
        .clk, .rst_n, .issue, .issue_valid, .unit_ready, .wb_packet
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Sampled at the edge, before any register update
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (rst_n && wb_packet.valid) begin
            pkt_q.push_back(wb_packet);
            stamp_q.push_back(cycle_cnt);
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, writeback never arrived", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    ////////////////////
    // Models
    function automatic logic [XLEN-1:0] xorshift32(input logic [XLEN-1:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [XLEN-1:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic unit_id_e unit_of(input op_e op);
        if (op == OP_MUL) begin
            return UNIT_MUL;
        end else if (op == OP_DIVU || op == OP_REMU) begin
            return UNIT_DIV;
        end
        return UNIT_ALU;
    endfunction

    // Expected result per RISC-V rules, zero divisor included
    function automatic logic [XLEN-1:0] model_op(input op_e op, input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            OP_LUI:  return b;
            OP_MUL:  return a * b;
            OP_DIVU: return (b == '0) ? '1 : a / b;
            default: return (b == '0) ? a : a % b;
        endcase
    endfunction

    ////////////////////
    // Driving and checking
    task automatic check(input string name, input logic [XLEN-1:0] exp,
                         input logic [XLEN-1:0] act);
        if (exp !== act) begin
            errors = errors + 1;
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // Called 1 ns after an edge, returns 1 ns after the issue edge
    task automatic issue_op(input op_e op, input reg_addr_t rd, input reg_addr_t rs1,
                            input reg_addr_t rs2, input logic use_imm,
                            input logic [XLEN-1:0] imm, output wb_packet_t exp);
        unit_id_e        unit;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        unit = unit_of(op);
        a = ref_regs[rs1];
        b = use_imm ? imm : ref_regs[rs2];
        while (!unit_ready[unit]) begin
            @(posedge clk);
            #1;
        end
        issue = '{op: op, id: next_id, rd_addr: rd, rs1_addr: rs1, rs2_addr: rs2,
                  use_imm: use_imm, imm: imm};
        issue_valid = 1'b1;
        exp = '{valid: 1'b1, id: next_id, rd_addr: rd, data: model_op(op, a, b)};
        // x0 stays zero in the model too
        if (rd != '0) begin
            ref_regs[rd] = exp.data;
        end
        next_id = next_id + 1'b1;
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
    endtask

    task automatic wait_result(input string name, input wb_packet_t exp, output int at);
        wb_packet_t got;
        while (pkt_q.size() == 0) begin
            @(posedge clk);
            #1;
        end
        got = pkt_q.pop_front();
        at = stamp_q.pop_front();
        check({name, " id"}, exp.id, got.id);
        check({name, " rd"}, exp.rd_addr, got.rd_addr);
        check({name, " data"}, exp.data, got.data);
    endtask

    task automatic run_op(input string name, input op_e op, input reg_addr_t rd,
                          input reg_addr_t rs1, input reg_addr_t rs2, input logic use_imm,
                          input logic [XLEN-1:0] imm);
        wb_packet_t exp;
        int         at;
        issue_op(op, rd, rs1, rs2, use_imm, imm, exp);
        wait_result(name, exp, at);
    endtask

    ////////////////////
    // Tests
    task automatic test_reset();
        check("reset valid", 1'b0, wb_packet.valid);
        check("reset ready", 3'b111, unit_ready);
    endtask

    task automatic test_alu_ops();
        op_e ops [4];
        ops = '{OP_ADD, OP_SUB, OP_AND, OP_XOR};
        // Seed x1..x4 through the ALU pass-through
        for (int r = 1; r <= 4; r++) begin
            run_op("alu_ops lui", OP_LUI, reg_addr_t'(r), '0, '0, 1'b1, rand_word());
        end
        for (int i = 0; i < 4; i++) begin
            run_op({"alu_ops reg ", ops[i].name()}, ops[i], reg_addr_t'(5 + i),
                   5'd1, 5'd2, 1'b0, '0);
            run_op({"alu_ops imm ", ops[i].name()}, ops[i], reg_addr_t'(10 + i),
                   5'd3, '0, 1'b1, rand_word());
        end
        // Packet still shows up, storage must not change
        run_op("alu_ops x0 write", OP_ADD, '0, 5'd1, 5'd2, 1'b0, '0);
        run_op("alu_ops x0 read", OP_ADD, 5'd15, '0, 5'd4, 1'b0, '0);
    endtask

    task automatic test_mul_pipeline();
        wb_packet_t exp0;
        wb_packet_t exp1;
        int         at0;
        int         at1;
        issue_op(OP_MUL, 5'd20, 5'd1, 5'd2, 1'b0, '0, exp0);
        check("mul_pipeline ready", 1'b1, unit_ready[UNIT_MUL]);
        issue_op(OP_MUL, 5'd21, 5'd3, '0, 1'b1, rand_word(), exp1);
        wait_result("mul_pipeline first", exp0, at0);
        wait_result("mul_pipeline second", exp1, at1);
        // Back to back in, back to back out
        check("mul_pipeline spacing", at0 + 1, at1);
    endtask

    task automatic div_case(input string name, input op_e op, input reg_addr_t rd,
                            input reg_addr_t rs1, input reg_addr_t rs2, input logic use_imm,
                            input logic [XLEN-1:0] imm);
        wb_packet_t exp;
        int         at;
        issue_op(op, rd, rs1, rs2, use_imm, imm, exp);
        // Locked out for the whole division, packet cycle included
        while (pkt_q.size() == 0) begin
            check({name, " ready low"}, 1'b0, unit_ready[UNIT_DIV]);
            @(posedge clk);
            #1;
        end
        wait_result(name, exp, at);
        check({name, " ready high"}, 1'b1, unit_ready[UNIT_DIV]);
    endtask

    task automatic test_div();
        logic [XLEN-1:0] divisor;
        div_case("div divu reg", OP_DIVU, 5'd22, 5'd1, 5'd2, 1'b0, '0);
        div_case("div remu reg", OP_REMU, 5'd23, 5'd1, 5'd2, 1'b0, '0);
        // Small divisor for a wide quotient
        divisor = (rand_word() >> 20) | 32'd1;
        div_case("div divu small", OP_DIVU, 5'd24, 5'd3, '0, 1'b1, divisor);
        div_case("div remu small", OP_REMU, 5'd25, 5'd3, '0, 1'b1, divisor);
        div_case("div divu zero", OP_DIVU, 5'd24, 5'd4, '0, 1'b1, '0);
        div_case("div remu zero", OP_REMU, 5'd25, 5'd4, '0, 1'b1, '0);
    endtask

    task automatic test_priority();
        wb_packet_t mul_exp;
        wb_packet_t alu_exp;
        int         at_mul;
        int         at_alu;
        // MUL first, ALU a cycle later, both done together
        issue_op(OP_MUL, 5'd26, 5'd1, 5'd3, 1'b0, '0, mul_exp);
        issue_op(OP_XOR, 5'd27, 5'd2, '0, 1'b1, rand_word(), alu_exp);
        wait_result("priority alu first", alu_exp, at_alu);
        wait_result("priority mul second", mul_exp, at_mul);
        check("priority spacing", at_alu + 1, at_mul);
        run_op("priority dependent", OP_ADD, 5'd28, 5'd26, 5'd27, 1'b0, '0);
    endtask

    ////////////////////
    // Sequence
    initial begin
        rst_n       = 1'b0;
        issue       = '0;
        issue_valid = 1'b0;
        for (int i = 0; i < 2**REG_ADDR_W; i++) begin
            ref_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset();
        test_alu_ops();
        test_mul_pipeline();
        test_div();
        test_priority();

        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog/exec_backend_top.sv ====
/*
 * Execution backend top
 * Reads operands, steers each issue to ALU, multiplier or divider,
 * and returns results through the writeback arbiter
 */

`timescale 1ns/1ps

module exec_backend_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  wb_pkg::issue_t                  issue,
    input  logic                            issue_valid,
    output logic [wb_pkg::NUM_WB_UNITS-1:0] unit_ready,
    output wb_pkg::wb_packet_t              wb_packet
);
    import wb_pkg::*;

    unit_id_e                target;
    exec_req_t               req;
    logic [XLEN-1:0]         rs1_data;
    logic [XLEN-1:0]         rs2_data;
    logic [NUM_WB_UNITS-1:0] unit_issue;
    logic [NUM_WB_UNITS-1:0] unit_ack;
    unit_wb_t                unit_wb [NUM_WB_UNITS];

    ////////////////////
    // Steering
    always_comb begin
        case (issue.op)
            OP_MUL:          target = UNIT_MUL;
            OP_DIVU, OP_REMU: target = UNIT_DIV;
            default:         target = UNIT_ALU;
        endcase
    end

    assign req = '{
        op:      issue.op,
        id:      issue.id,
        rd_addr: issue.rd_addr,
        src_a:   rs1_data,
        src_b:   issue.use_imm ? issue.imm : rs2_data
    };

    // One strobe per cycle, to the target only
    assign unit_issue = NUM_WB_UNITS'(issue_valid) << target;

    reg_file u_reg_file (
        .clk, .rst_n,
        .rs1_addr (issue.rs1_addr),
        .rs2_addr (issue.rs2_addr),
        .rs1_data, .rs2_data,
        .wb       (wb_packet)
    );

    alu_unit u_alu (
        .clk, .rst_n, .req,
        .issue (unit_issue[UNIT_ALU]),
        .ack   (unit_ack[UNIT_ALU]),
        .ready (unit_ready[UNIT_ALU]),
        .wb    (unit_wb[UNIT_ALU])
    );

    mul_unit u_mul (
        .clk, .rst_n, .req,
        .issue (unit_issue[UNIT_MUL]),
        .ack   (unit_ack[UNIT_MUL]),
        .ready (unit_ready[UNIT_MUL]),
        .wb    (unit_wb[UNIT_MUL])
    );

    div_unit u_div (
        .clk, .rst_n, .req,
        .issue (unit_issue[UNIT_DIV]),
        .ack   (unit_ack[UNIT_DIV]),
        .ready (unit_ready[UNIT_DIV]),
        .wb    (unit_wb[UNIT_DIV])
    );

    writeback u_writeback (
        .clk, .rst_n, .unit_wb, .wb_packet,
        .ack (unit_ack)
    );

    // Issuer must respect the target unit's ready level
    a_issue_ready: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> unit_ready[target])
        else $error("Issue to unit %0d while not ready", target);

endmodule

// ==== verilog/writeback.sv ====
/*
 * Fixed-priority writeback arbiter
 * Picks the lowest-index done unit each cycle, acks it and
 * forwards its result as the writeback packet, zero latency
 */

`timescale 1ns/1ps

module writeback (
    input  logic               clk,
    input  logic               rst_n,
    input  wb_pkg::unit_wb_t   unit_wb [wb_pkg::NUM_WB_UNITS],
    output logic [wb_pkg::NUM_WB_UNITS-1:0] ack,
    output wb_pkg::wb_packet_t wb_packet
);
    import wb_pkg::*;

    logic [NUM_WB_UNITS-1:0] done_vec;
    logic                    any_done;
    unit_id_e                sel;

    ////////////////////
    // Priority select
    // Walk from highest index down so the lowest done unit wins
    always_comb begin
        sel = UNIT_ALU;
        for (int i = NUM_WB_UNITS - 1; i >= 0; i--) begin
            done_vec[i] = unit_wb[i].done;
            if (unit_wb[i].done) begin
                sel = unit_id_e'(i);
            end
        end
    end

    assign any_done = |done_vec;

    // Winner only, nothing when idle
    assign ack = NUM_WB_UNITS'(any_done) << sel;

    assign wb_packet = '{
        valid:   any_done,
        id:      unit_wb[sel].id,
        rd_addr: unit_wb[sel].rd_addr,
        data:    unit_wb[sel].data
    };

    ////////////////////
    // Handshake checks
    for (genvar g = 0; g < NUM_WB_UNITS; g++) begin : gen_wb_checks
        a_ack_done: assert property (@(posedge clk) disable iff (!rst_n)
            ack[g] |-> unit_wb[g].done)
            else $error("Ack to unit %0d without done", g);

        // Losing unit keeps its result for the next round
        a_hold: assert property (@(posedge clk) disable iff (!rst_n)
            unit_wb[g].done && !ack[g] |=> unit_wb[g].done
                && $stable(unit_wb[g].id)
                && $stable(unit_wb[g].rd_addr)
                && $stable(unit_wb[g].data))
            else $error("Unit %0d dropped an unacked result", g);
    end

endmodule

// ==== verilog/div_unit.sv ====
/*
 * Iterative radix-2 unsigned divider
 * Restoring shift-subtract, one quotient bit per cycle over 32 cycles
 * Presents quotient or remainder and holds done until ack
 */

`timescale 1ns/1ps

module div_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue,
    input  wb_pkg::exec_req_t req,
    input  logic              ack,
    output logic              ready,
    output wb_pkg::unit_wb_t  wb
);
    import wb_pkg::*;

    // Control
    logic                 busy_q;
    logic                 done_q;
    logic [DIV_CNT_W-1:0] cnt_q;
    logic                 last_step;
    // Datapath
    logic [XLEN-1:0]      quo_q;
    logic [XLEN-1:0]      rem_q;
    logic [XLEN-1:0]      dvs_q;
    logic                 rem_sel_q;
    id_t                  id_q;
    reg_addr_t            rd_q;
    logic [XLEN:0]        shifted;
    logic [XLEN:0]        diff;

    // Locked out from issue until the ack edge
    assign ready     = !busy_q && !done_q;
    assign last_step = (cnt_q == DIV_CNT_W'(XLEN - 1));

    // Next dividend bit shifted into the partial remainder
    assign shifted = {rem_q, quo_q[XLEN-1]};
    // Borrow in the top bit means divisor did not fit
    assign diff    = shifted - {1'b0, dvs_q};

    ////////////////////
    // Sequencing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (issue) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (last_step) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end else if (ack) begin
            done_q <= 1'b0;
        end
    end

    ////////////////////
    // Shift-subtract
    // Zero divisor never borrows, so quotient fills with ones and the
    // remainder ends up as the dividend, matching the RISC-V rule
    always_ff @(posedge clk) begin
        if (issue) begin
            quo_q     <= req.src_a;
            rem_q     <= '0;
            dvs_q     <= req.src_b;
            rem_sel_q <= (req.op == OP_REMU);
            id_q      <= req.id;
            rd_q      <= req.rd_addr;
        end else if (busy_q) begin
            if (!diff[XLEN]) begin
                rem_q <= diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shifted[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    assign wb = '{
        done:    done_q,
        id:      id_q,
        rd_addr: rd_q,
        data:    rem_sel_q ? rem_q : quo_q
    };

    // One division at a time
    a_no_issue_busy: assert property (@(posedge clk) disable iff (!rst_n)
        issue |-> !busy_q && !done_q)
        else $error("DIV issue while busy");

endmodule

// ==== verilog/mul_unit.sv ====
/*
 * Two-stage pipelined multiplier, low word of a 32x32 product
 * Stage one captures operands, stage two is the output slot
 * Stalls back up from an unacked output
 */

`timescale 1ns/1ps

module mul_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue,
    input  wb_pkg::exec_req_t req,
    input  logic              ack,
    output logic              ready,
    output wb_pkg::unit_wb_t  wb
);
    import wb_pkg::*;

    // Stage one
    logic            s1_valid;
    id_t             s1_id;
    reg_addr_t       s1_rd;
    logic [XLEN-1:0] s1_a;
    logic [XLEN-1:0] s1_b;
    // Output slot
    logic            out_valid;
    id_t             out_id;
    reg_addr_t       out_rd;
    logic [XLEN-1:0] out_data;

    logic            out_free;
    logic [XLEN-1:0] product;

    // Output slot empty or draining this edge
    assign out_free = !out_valid || ack;
    // Stage one can take a new op if empty or moving on
    assign ready    = !s1_valid || out_free;
    // Low word only, upper half discarded
    assign product  = s1_a * s1_b;

    ////////////////////
    // Valid bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (issue) begin
                s1_valid <= 1'b1;
            end else if (out_free) begin
                s1_valid <= 1'b0;
            end
            if (out_free) begin
                out_valid <= s1_valid;
            end
        end
    end

    ////////////////////
    // Payload
    always_ff @(posedge clk) begin
        if (issue) begin
            s1_id <= req.id;
            s1_rd <= req.rd_addr;
            s1_a  <= req.src_a;
            s1_b  <= req.src_b;
        end
        if (out_free && s1_valid) begin
            out_id   <= s1_id;
            out_rd   <= s1_rd;
            out_data <= product;
        end
    end

    assign wb = '{done: out_valid, id: out_id, rd_addr: out_rd, data: out_data};

    // Stage one stalled means no room for a new operand
    a_s1_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
        issue |-> (!s1_valid || out_free))
        else $error("MUL issue into stalled stage one");

endmodule

// ==== verilog/alu_unit.sv ====
/*
 * Single-cycle integer ALU
 * Add, sub, and, xor and lui pass-through, result held with its
 * tag until the writeback arbiter acks it
 */

`timescale 1ns/1ps

module alu_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue,
    input  wb_pkg::exec_req_t req,
    input  logic              ack,
    output logic              ready,
    output wb_pkg::unit_wb_t  wb
);
    import wb_pkg::*;

    logic            done_q;
    id_t             id_q;
    reg_addr_t       rd_q;
    logic [XLEN-1:0] data_q;
    logic [XLEN-1:0] result;

    ////////////////////
    // Datapath
    always_comb begin
        case (req.op)
            OP_SUB:  result = req.src_a - req.src_b;
            OP_AND:  result = req.src_a & req.src_b;
            OP_XOR:  result = req.src_a ^ req.src_b;
            // Immediate already shifted by the issuer
            OP_LUI:  result = req.src_b;
            default: result = req.src_a + req.src_b;
        endcase
    end

    // Free when empty or when the held result leaves this edge
    assign ready = !done_q || ack;

    ////////////////////
    // Result slot
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else if (issue) begin
            done_q <= 1'b1;
        end else if (ack) begin
            done_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            id_q   <= req.id;
            rd_q   <= req.rd_addr;
            data_q <= result;
        end
    end

    assign wb = '{done: done_q, id: id_q, rd_addr: rd_q, data: data_q};

    // Held result must not be overwritten
    a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
        issue |-> (!done_q || ack))
        else $error("ALU issue while result held");

endmodule

// ==== verilog/reg_file.sv ====
/*
 * Integer register file, 32 x 32
 * Two asynchronous read ports, one write port from writeback
 * x0 is never written and reads zero
 */

`timescale 1ns/1ps

module reg_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  wb_pkg::reg_addr_t        rs1_addr,
    input  wb_pkg::reg_addr_t        rs2_addr,
    output logic [wb_pkg::XLEN-1:0]  rs1_data,
    output logic [wb_pkg::XLEN-1:0]  rs2_data,
    input  wb_pkg::wb_packet_t       wb
);
    import wb_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    ////////////////////
    // Write port
    // Entry 0 only sees the reset clear
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && (wb.rd_addr != '0)) begin
            regs[wb.rd_addr] <= wb.data;
        end
    end

    // Reads see the old value in the write cycle
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

// ==== verilog/wb_pkg.sv ====
/*
 * Execution backend shared definitions
 * Widths, operation and unit encodings, and the packed structs
 * passed between issue, the execution units and writeback
 */

package wb_pkg;

    ////////////////////
    // Widths
    localparam int XLEN         = 32;
    localparam int REG_ADDR_W   = 5;
    localparam int ID_W         = 4;
    localparam int NUM_WB_UNITS = 3;
    // Divider iteration counter, one step per quotient bit
    localparam int DIV_CNT_W    = $clog2(XLEN);

    typedef logic [ID_W-1:0]       id_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    ////////////////////
    // Encodings
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR,
        OP_LUI,
        OP_MUL,
        OP_DIVU,
        OP_REMU
    } op_e;

    // Declaration order is writeback priority, lowest index wins
    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_MUL,
        UNIT_DIV
    } unit_id_e;

    ////////////////////
    // Bundles
    // Issue request from the outside
    typedef struct packed {
        op_e              op;
        id_t              id;
        reg_addr_t        rd_addr;
        reg_addr_t        rs1_addr;
        reg_addr_t        rs2_addr;
        logic             use_imm;
        logic [XLEN-1:0]  imm;
    } issue_t;

    // Operands resolved, sent to one unit
    typedef struct packed {
        op_e              op;
        id_t              id;
        reg_addr_t        rd_addr;
        logic [XLEN-1:0]  src_a;
        logic [XLEN-1:0]  src_b;
    } exec_req_t;

    // Unit result toward the arbiter
    typedef struct packed {
        logic             done;
        id_t              id;
        reg_addr_t        rd_addr;
        logic [XLEN-1:0]  data;
    } unit_wb_t;

    // Selected result, also the register file write
    typedef struct packed {
        logic             valid;
        id_t              id;
        reg_addr_t        rd_addr;
        logic [XLEN-1:0]  data;
    } wb_packet_t;

endpackage
